// ==== rtl/merge_defines.svh ====
// Size and threshold macros for the merge data engine
`ifndef MERGE_DEFINES_SVH
`define MERGE_DEFINES_SVH

// Lane count and word width
`define MERGE_LANES      4
`define MERGE_DATA_W     32

// Lane buffer sizing
`define LANE_FIFO_DEPTH  8

// Reserve room for the staged word and one more accepted in the same cycle
`define LANE_PROG_THRESH (`LANE_FIFO_DEPTH - 2)

`endif

// ==== rtl/merge_pkg.sv ====
// Shared word, lane and control types of the merge data engine
`include "merge_defines.svh"

package merge_pkg;

    localparam int LANE_ID_W = (`MERGE_LANES > 1) ? $clog2(`MERGE_LANES) : 1;

    typedef logic [`MERGE_DATA_W-1:0] merge_word_t;
    typedef logic [LANE_ID_W-1:0]     lane_id_t;
    typedef logic [`MERGE_LANES-1:0]  lane_mask_t;

    // Configuration port opcodes
    typedef enum logic [1:0] {
        CFG_NOP         = 2'd0,
        CFG_SET_MASK    = 2'd1,
        CFG_DISABLE_ALL = 2'd2
    } cfg_op_e;

    typedef enum logic [1:0] {
        SEQ_SEEK      = 2'd0,
        SEQ_WAIT_LANE = 2'd1,
        SEQ_HOLD_OUT  = 2'd2
    } seq_state_e;

endpackage : merge_pkg

// ==== rtl/lane_if.sv ====
// Lane channel linking the ingress stage, one lane FIFO and the sequencer
`timescale 1ns/1ps

interface lane_if;
    import merge_pkg::*;

    // Push side, fed from the ingress staging register
    logic        push_valid;
    merge_word_t push_data;

    // Pop side toward the sequencer
    logic        pop_ready;
    logic        pop_valid;
    merge_word_t pop_data;

    // Fill status
    logic        almost_full;
    logic        empty;

    modport ingress (output push_valid, output push_data, input almost_full);

    modport fifo (
        input  push_valid, push_data, pop_ready,
        output pop_valid, pop_data, almost_full, empty
    );

    modport seq (output pop_ready, input pop_valid, pop_data, empty);

endinterface : lane_if

// ==== rtl/merge_ingress.sv ====
// Ingress stage with per-lane staging registers, the lane-enable register and ready
`timescale 1ns/1ps
`include "merge_defines.svh"

module merge_ingress (
    input  logic                    ap_clk,
    input  logic                    areset_csr_engine,
    input  logic [`MERGE_LANES-1:0] response_valid,
    input  merge_pkg::merge_word_t  response_data [`MERGE_LANES-1:0],
    output logic [`MERGE_LANES-1:0] response_ready,
    input  logic                    cfg_valid,
    input  merge_pkg::cfg_op_e      cfg_op,
    input  merge_pkg::lane_mask_t   cfg_mask,
    output merge_pkg::lane_mask_t   lane_mask,
    output logic                    staging_busy,
    lane_if.ingress                 lanes [`MERGE_LANES-1:0]
);
    import merge_pkg::*;

    logic [`MERGE_LANES-1:0] stage_valid;
    merge_word_t             stage_data [`MERGE_LANES-1:0];

    // Lane enable register
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            lane_mask <= '0;
        end else if (cfg_valid) begin
            case (cfg_op)
                CFG_SET_MASK:    lane_mask <= cfg_mask;
                CFG_DISABLE_ALL: lane_mask <= '0;
                default:         lane_mask <= lane_mask;
            endcase
        end
    end

    // One staging slot per lane, pushed into the FIFO the next cycle
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= response_valid & response_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < `MERGE_LANES; i++) begin
            if (response_valid[i] && response_ready[i]) begin
                stage_data[i] <= response_data[i];
            end
        end
    end

    for (genvar g = 0; g < `MERGE_LANES; g++) begin : g_lane
        assign response_ready[g]   = lane_mask[g] & ~lanes[g].almost_full;
        assign lanes[g].push_valid = stage_valid[g];
        assign lanes[g].push_data  = stage_data[g];

        // A push into an almost-full lane must keep the lane flagged
        a_no_push_past_thresh : assert property (
            @(posedge ap_clk) disable iff (areset_csr_engine)
            (lanes[g].push_valid && lanes[g].almost_full) |=> lanes[g].almost_full
        ) else $error("lane %0d dropped almost full while taking a push", g);
    end

    assign staging_busy = |stage_valid;

endmodule : merge_ingress

// ==== rtl/merge_lane_fifo.sv ====
// Lane buffer with circular storage, fall-through output register and almost-full flag
`timescale 1ns/1ps
`include "merge_defines.svh"

module merge_lane_fifo (
    input logic  ap_clk,
    input logic  areset_csr_engine,
    lane_if.fifo lane
);
    import merge_pkg::*;

    localparam int DEPTH   = `LANE_FIFO_DEPTH;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 2);

    merge_word_t        mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] mem_count;
    logic               out_valid;
    merge_word_t        out_data;
    logic               pop;
    logic               out_load;
    logic               mem_empty;
    logic               mem_full;
    logic               mem_read;
    logic               mem_write;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // -------------------------------------------------------------------------
    // Storage control
    // -------------------------------------------------------------------------
    assign pop       = out_valid & lane.pop_ready;
    assign out_load  = ~out_valid | pop;
    assign mem_empty = (mem_count == '0);
    assign mem_full  = (mem_count == COUNT_W'(DEPTH));
    assign mem_read  = out_load & ~mem_empty;
    // Bypass straight into the output register when storage is empty
    assign mem_write = lane.push_valid & ~(out_load & mem_empty);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_count <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_write) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (mem_read) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            mem_count <= mem_count + COUNT_W'(mem_write) - COUNT_W'(mem_read);
            if (out_load) begin
                out_valid <= ~mem_empty | lane.push_valid;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (mem_write) begin
            mem[wr_ptr] <= lane.push_data;
        end
        if (mem_read) begin
            out_data <= mem[rd_ptr];
        end else if (out_load && lane.push_valid) begin
            out_data <= lane.push_data;
        end
    end

    assign lane.pop_valid   = out_valid;
    assign lane.pop_data    = out_data;
    assign lane.empty       = ~out_valid & mem_empty;
    assign lane.almost_full =
        (mem_count + COUNT_W'(out_valid)) >= COUNT_W'(`LANE_PROG_THRESH);

    // Ingress threshold must keep pushes away from a full buffer
    a_no_overflow : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        lane.push_valid |-> !(mem_full && !mem_read)
    ) else $error("push into a full lane FIFO");

endmodule : merge_lane_fifo

// ==== rtl/merge_sequencer.sv ====
// Sequencer that rotates over enabled lanes and registers the merged request
`timescale 1ns/1ps
`include "merge_defines.svh"

module merge_sequencer (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  merge_pkg::lane_mask_t  lane_mask,
    input  logic                   staging_busy,
    input  logic                   request_ready,
    output logic                   request_valid,
    output merge_pkg::lane_id_t    request_lane,
    output merge_pkg::merge_word_t request_data,
    output logic                   done,
    lane_if.seq                    lanes [`MERGE_LANES-1:0]
);
    import merge_pkg::*;

    seq_state_e              state;
    lane_id_t                ptr;
    lane_id_t                next_ptr;
    lane_mask_t              mask_q;
    logic                    restart;
    logic                    mask_changed;
    logic                    found;
    logic                    pop;
    logic                    done_q;
    logic [`MERGE_LANES-1:0] lane_valid;
    logic [`MERGE_LANES-1:0] lane_empty;
    logic [`MERGE_LANES-1:0] lane_ready;
    merge_word_t             lane_data [`MERGE_LANES-1:0];

    for (genvar g = 0; g < `MERGE_LANES; g++) begin : g_lane
        assign lane_valid[g]      = lanes[g].pop_valid;
        assign lane_data[g]       = lanes[g].pop_data;
        assign lane_empty[g]      = lanes[g].empty;
        assign lane_ready[g]      = (state == SEQ_WAIT_LANE) && !mask_changed &&
                                    (ptr == lane_id_t'(g));
        assign lanes[g].pop_ready = lane_ready[g];
    end

    assign mask_changed = (lane_mask != mask_q);
    assign pop          = |(lane_valid & lane_ready);

    // Next enabled lane after ptr, or the lowest one on restart
    always_comb begin : next_lane_search
        int start;
        int idx;
        next_ptr = ptr;
        found    = 1'b0;
        start    = restart ? 0 : int'(ptr) + 1;
        for (int k = 0; k < `MERGE_LANES; k++) begin
            idx = (start + k) % `MERGE_LANES;
            if (!found && lane_mask[idx]) begin
                next_ptr = lane_id_t'(idx);
                found    = 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Rotation FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state         <= SEQ_SEEK;
            ptr           <= '0;
            mask_q        <= '0;
            restart       <= 1'b1;
            request_valid <= 1'b0;
        end else begin
            mask_q <= lane_mask;
            case (state)
                SEQ_SEEK: begin
                    if (mask_changed) begin
                        restart <= 1'b1;
                    end else if (found) begin
                        ptr     <= next_ptr;
                        restart <= 1'b0;
                        state   <= SEQ_WAIT_LANE;
                    end
                end
                SEQ_WAIT_LANE: begin
                    if (mask_changed) begin
                        restart <= 1'b1;
                        state   <= SEQ_SEEK;
                    end else if (pop) begin
                        request_valid <= 1'b1;
                        state         <= SEQ_HOLD_OUT;
                    end
                end
                SEQ_HOLD_OUT: begin
                    if (mask_changed) begin
                        restart <= 1'b1;
                    end
                    if (request_ready) begin
                        request_valid <= 1'b0;
                        state         <= SEQ_SEEK;
                    end
                end
                default: state <= SEQ_SEEK;
            endcase
        end
    end

    // Output word, tagged with its lane
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            request_lane <= ptr;
            request_data <= lane_data[ptr];
        end
    end

    // Idle means nothing staged, buffered or waiting at the output
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            done_q <= 1'b1;
        end else begin
            done_q <= !staging_busy && (&lane_empty) && !request_valid;
        end
    end

    assign done = done_q & ~staging_busy;

    a_stall_stable : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        (request_valid && !request_ready) |=>
            (request_valid && $stable(request_lane) && $stable(request_data))
    ) else $error("request changed while stalled");

endmodule : merge_sequencer

// ==== rtl/merge_data_engine.sv ====
// Merge data engine top joining the lane ingress, lane FIFOs and the sequencer
`timescale 1ns/1ps
`include "merge_defines.svh"

module merge_data_engine (
    input  logic                    ap_clk,
    input  logic                    areset_csr_engine,
    // Per-lane input streams
    input  logic [`MERGE_LANES-1:0] response_valid,
    input  merge_pkg::merge_word_t  response_data [`MERGE_LANES-1:0],
    output logic [`MERGE_LANES-1:0] response_ready,
    // Configuration
    input  logic                    cfg_valid,
    input  merge_pkg::cfg_op_e      cfg_op,
    input  merge_pkg::lane_mask_t   cfg_mask,
    // Merged request stream
    output logic                    request_valid,
    output merge_pkg::lane_id_t     request_lane,
    output merge_pkg::merge_word_t  request_data,
    input  logic                    request_ready,
    output logic                    done
);
    import merge_pkg::*;

    lane_mask_t lane_mask;
    logic       staging_busy;

    lane_if lanes [`MERGE_LANES-1:0] ();

    merge_ingress u_ingress (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_valid    (response_valid),
        .response_data     (response_data),
        .response_ready    (response_ready),
        .cfg_valid         (cfg_valid),
        .cfg_op            (cfg_op),
        .cfg_mask          (cfg_mask),
        .lane_mask         (lane_mask),
        .staging_busy      (staging_busy),
        .lanes             (lanes)
    );

    // One buffer per lane
    for (genvar g = 0; g < `MERGE_LANES; g++) begin : g_fifo
        merge_lane_fifo u_lane_fifo (
            .ap_clk            (ap_clk),
            .areset_csr_engine (areset_csr_engine),
            .lane              (lanes[g])
        );
    end

    merge_sequencer u_sequencer (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .lane_mask         (lane_mask),
        .staging_busy      (staging_busy),
        .request_ready     (request_ready),
        .request_valid     (request_valid),
        .request_lane      (request_lane),
        .request_data      (request_data),
        .done              (done),
        .lanes             (lanes)
    );

endmodule : merge_data_engine

// ==== tb/tb_merge_data_engine.sv ====
// Testbench for the merge data engine with random lane traffic and a rotation model
`timescale 1ns/1ps
`include "merge_defines.svh"

module tb_merge_data_engine;
    import merge_pkg::*;

    localparam int LANES     = `MERGE_LANES;
    localparam int TIMEOUT   = 4000;
    localparam int DRIVE_DLY = 2;

    logic             ap_clk;
    logic             areset_csr_engine;
    logic [LANES-1:0] response_valid;
    merge_word_t      response_data [LANES-1:0];
    logic [LANES-1:0] response_ready;
    logic             cfg_valid;
    cfg_op_e          cfg_op;
    lane_mask_t       cfg_mask;
    logic             request_valid;
    lane_id_t         request_lane;
    merge_word_t      request_data;
    logic             request_ready;
    logic             done;

    // Reference model
    merge_word_t      model_q [LANES][$];
    lane_mask_t       model_mask;
    int               rot_next;
    int               sent [LANES];
    int               words_per_lane;
    int               stall_pct;
    int               valid_pct;
    logic [LANES-1:0] taken;
    logic             was_stalled;
    lane_id_t         held_lane;
    merge_word_t      held_data;
    int               error_count;

    merge_data_engine UUT (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_valid    (response_valid),
        .response_data     (response_data),
        .response_ready    (response_ready),
        .cfg_valid         (cfg_valid),
        .cfg_op            (cfg_op),
        .cfg_mask          (cfg_mask),
        .request_valid     (request_valid),
        .request_lane      (request_lane),
        .request_data      (request_data),
        .request_ready     (request_ready),
        .done              (done)
    );

    initial ap_clk = 1'b0;
    always #10 ap_clk = ~ap_clk;

    // First enabled lane at or after start, wrapping around
    function automatic int lane_from(input lane_mask_t mask, input int start);
        int idx;
        for (int k = 0; k < LANES; k++) begin
            idx = (start + k) % LANES;
            if (mask[idx]) begin
                return idx;
            end
        end
        return 0;
    endfunction

    function automatic logic traffic_finished();
        for (int i = 0; i < LANES; i++) begin
            if ((model_mask[i] && sent[i] != words_per_lane) || model_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return done;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "Stopping after a timeout");
    endtask

    // ------------------------------------------------------------------------
    // Per-cycle sampling and driving
    // ------------------------------------------------------------------------
    // Sampled at the falling edge, this is what the next rising edge transfers
    task automatic sample_cycle();
        int          total;
        int          exp_lane;
        merge_word_t exp_data;
        @(negedge ap_clk);
        total = 0;
        for (int i = 0; i < LANES; i++) begin
            total += model_q[i].size();
        end
        check_value("pending words while done", done ? total : 0, 0);
        check_value("response_ready outside mask", response_ready & ~model_mask, 0);
        if (was_stalled) begin
            check_value("request_valid while stalled", request_valid, 1);
            check_value("request_lane while stalled", request_lane, held_lane);
            check_value("request_data while stalled", request_data, held_data);
        end
        taken = response_valid & response_ready;
        for (int i = 0; i < LANES; i++) begin
            if (taken[i]) begin
                model_q[i].push_back(response_data[i]);
                sent[i]++;
            end
        end
        if (request_valid && request_ready) begin
            exp_lane = rot_next;
            check_value("request_lane", request_lane, exp_lane);
            check_value("model queue depth", model_q[exp_lane].size() != 0, 1);
            exp_data = model_q[exp_lane].pop_front();
            check_value("request_data", request_data, exp_data);
            rot_next = lane_from(model_mask, exp_lane + 1);
        end
        was_stalled = request_valid && !request_ready;
        held_lane   = request_lane;
        held_data   = request_data;
    endtask

    task automatic drive_cycle();
        @(posedge ap_clk);
        #DRIVE_DLY;
        for (int i = 0; i < LANES; i++) begin
            // A word not yet taken stays on the bus
            if (!response_valid[i] || taken[i]) begin
                if (model_mask[i] && sent[i] < words_per_lane &&
                    $urandom_range(99) < valid_pct) begin
                    response_valid[i] = 1'b1;
                    response_data[i]  = $urandom;
                end else begin
                    response_valid[i] = 1'b0;
                end
            end
        end
        request_ready = ($urandom_range(99) >= stall_pct);
    endtask

    task automatic run_cycle();
        sample_cycle();
        drive_cycle();
    endtask

    task automatic start_traffic(input int words, input int stall, input int valid);
        words_per_lane = words;
        stall_pct      = stall;
        valid_pct      = valid;
        for (int i = 0; i < LANES; i++) begin
            sent[i] = 0;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!traffic_finished()) begin
            run_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                timeout_fail("the lane traffic to drain and done to rise");
            end
        end
    endtask

    // Mask takes effect one cycle after the write
    task automatic write_cfg(input cfg_op_e op, input lane_mask_t mask);
        lane_mask_t old_mask;
        old_mask  = model_mask;
        cfg_valid = 1'b1;
        cfg_op    = op;
        cfg_mask  = mask;
        @(posedge ap_clk);
        #DRIVE_DLY;
        cfg_valid = 1'b0;
        cfg_op    = CFG_NOP;
        if (op == CFG_SET_MASK) begin
            model_mask = mask;
        end else if (op == CFG_DISABLE_ALL) begin
            model_mask = '0;
        end
        // Rotation restarts at the lowest lane only on a real mask change
        if (model_mask != old_mask) begin
            rot_next = lane_from(model_mask, 0);
        end
        @(posedge ap_clk);
        #DRIVE_DLY;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin : main
        int         waited;
        lane_mask_t subset;
        void'($urandom(71642));
        areset_csr_engine = 1'b1;
        response_valid    = '0;
        for (int i = 0; i < LANES; i++) begin
            response_data[i] = '0;
        end
        cfg_valid     = 1'b0;
        cfg_op        = CFG_NOP;
        cfg_mask      = '0;
        request_ready = 1'b0;
        model_mask    = '0;
        rot_next      = 0;
        taken         = '0;
        was_stalled   = 1'b0;
        error_count   = 0;
        start_traffic(0, 0, 0);
        repeat (2) @(posedge ap_clk);
        #DRIVE_DLY;
        areset_csr_engine = 1'b0;

        check_value("done after reset", done, 1);
        check_value("request_valid after reset", request_valid, 0);
        check_value("response_ready after reset", response_ready, 0);

        // All lanes with random stalls
        write_cfg(CFG_SET_MASK, '1);
        start_traffic(16, 30, 60);
        wait_drained();

        // Random lane subsets
        repeat (2) begin
            subset = lane_mask_t'($urandom_range(1, (1 << LANES) - 2));
            write_cfg(CFG_SET_MASK, subset);
            start_traffic(10, 40, 70);
            wait_drained();
        end

        // Hold the output until every lane stops accepting
        write_cfg(CFG_SET_MASK, '1);
        start_traffic(3 * `LANE_FIFO_DEPTH, 100, 90);
        waited = 0;
        do begin
            run_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                timeout_fail("response_ready to fall under back-pressure");
            end
        end while (response_ready != '0);
        repeat (8) run_cycle();
        stall_pct = 30;
        wait_drained();

        write_cfg(CFG_DISABLE_ALL, '0);
        response_valid = '1;
        repeat (4) begin
            @(negedge ap_clk);
            check_value("response_ready after disable", response_ready, 0);
        end
        response_valid = '0;

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_merge_data_engine

// ==== list.f ====
+incdir+rtl
rtl/merge_pkg.sv
rtl/lane_if.sv
rtl/merge_ingress.sv
rtl/merge_lane_fifo.sv
rtl/merge_sequencer.sv
rtl/merge_data_engine.sv
tb/tb_merge_data_engine.sv

// ==== Bender.yml ====
package:
  name: merge_data_engine

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/merge_pkg.sv
      - rtl/lane_if.sv
      - rtl/merge_ingress.sv
      - rtl/merge_lane_fifo.sv
      - rtl/merge_sequencer.sv
      - rtl/merge_data_engine.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/tb_merge_data_engine.sv
